// File: filelist.f
src/soc_xbar_pkg.sv
src/tcdm_if.sv
src/tcdm_master_port.sv
src/tcdm_target_arbiter.sv
src/tcdm_apb_bridge.sv
src/soc_xbar_top.sv
tests/soc_xbar_props.sv
tests/tb_soc_xbar.sv

// File: Makefile
TOP = tb_soc_xbar

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): filelist.f $(wildcard src/*.sv tests/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Verification failed" sim.log
	grep -q "Verification passed" sim.log

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: tests/tb_soc_xbar.sv
// Testbench for the SoC crossbar with memory and APB slave models and a scoreboard
`timescale 1ns/1ps
`default_nettype none

module tb_soc_xbar;
    import soc_xbar_pkg::*;

    localparam int NUM_TXN    = 200;
    localparam int TIMEOUT_NS = (2 * NUM_TXN) * 8 * 4 + 10 * 4;

    logic clk_i = 1'b0;
    logic rst_n_i;
    logic fc_data_req_i, fc_data_wen_i, fc_instr_req_i, fc_instr_wen_i;
    logic [31:0] fc_data_add_i, fc_data_wdata_i, fc_instr_add_i, fc_instr_wdata_i;
    logic [3:0] fc_data_be_i, fc_instr_be_i;
    logic fc_data_gnt_o, fc_data_r_valid_o, fc_data_r_opc_o;
    logic fc_instr_gnt_o, fc_instr_r_valid_o, fc_instr_r_opc_o;
    logic [31:0] fc_data_r_rdata_o, fc_instr_r_rdata_o;
    logic [3:0] l2_req_o, l2_wen_o, l2_gnt_i;
    logic [3:0][31:0] l2_add_o, l2_wdata_o, l2_rdata_i;
    logic [3:0][3:0] l2_be_o;
    logic [2:0] contig_req_o, contig_wen_o, contig_gnt_i;
    logic [2:0][31:0] contig_add_o, contig_wdata_o, contig_rdata_i;
    logic [2:0][3:0] contig_be_o;
    logic [31:0] paddr_o, pwdata_o, prdata_i;
    logic psel_o, penable_o, pwrite_o, pready_i, pslverr_i;

    // Per-master views of the two ports
    logic req [2];
    logic wen [2];
    logic [31:0] add [2];
    logic [31:0] wdata [2];
    logic [3:0] be [2];
    logic [1:0] gnt, rvalid, ropc;
    logic [31:0] rdata [2];

    // Models and scoreboard state
    logic [31:0] mem [logic [31:0]];
    logic [31:0] apb_regs [logic [31:0]];
    logic [31:0] ref_mem [logic [31:0]];
    logic [31:0] l2_rd_q [4];
    logic [31:0] contig_rd_q [3];
    int wait_cnt;
    logic pend [2];
    logic pend_rd [2];
    logic pend_err [2];
    logic pend_unm [2];
    logic [31:0] pend_data [2];
    logic lose_v [8];
    int lose_m [8];

    soc_xbar_top uut (.*);

    assign fc_data_req_i    = req[0];
    assign fc_data_add_i    = add[0];
    assign fc_data_wen_i    = wen[0];
    assign fc_data_wdata_i  = wdata[0];
    assign fc_data_be_i     = be[0];
    assign fc_instr_req_i   = req[1];
    assign fc_instr_add_i   = add[1];
    assign fc_instr_wen_i   = wen[1];
    assign fc_instr_wdata_i = wdata[1];
    assign fc_instr_be_i    = be[1];
    assign gnt      = {fc_instr_gnt_o, fc_data_gnt_o};
    assign rvalid   = {fc_instr_r_valid_o, fc_data_r_valid_o};
    assign ropc     = {fc_instr_r_opc_o, fc_data_r_opc_o};
    assign rdata[0] = fc_data_r_rdata_o;
    assign rdata[1] = fc_instr_r_rdata_o;

    always #2 clk_i = ~clk_i;

    task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic fail_text(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    // Data port alias rewrites prefix 0x000 to 0x1C0
    function automatic logic [31:0] remap(input int m, input logic [31:0] a);
        if (m == 0 && a[31:20] == LEGACY_PREFIX) return {SOC_PREFIX, a[19:0]};
        return a;
    endfunction

    // Target index from the memory map with 8 for unmapped
    function automatic int target_of(input logic [31:0] a);
        if (a >= L2_INTLV_START && a < L2_INTLV_END) return int'(a[3:2]);
        if (a >= PRIV_BANK0_START && a < PRIV_BANK0_END) return 4;
        if (a >= PRIV_BANK1_START && a < PRIV_BANK1_END) return 5;
        if (a >= BOOT_ROM_START && a < BOOT_ROM_END) return 6;
        if (a >= PERIPH_START && a < PERIPH_END) return 7;
        return 8;
    endfunction

    function automatic logic [31:0] pick_addr(input int rgn);
        logic [31:0] off;
        off = ($urandom % 16) * 4;
        case (rgn)
            0: return L2_INTLV_START + off;
            1: return PRIV_BANK0_START + off;
            2: return PRIV_BANK1_START + off;
            3: return BOOT_ROM_START + off;
            4: return PERIPH_START + off;
            5: return 32'h1A3F_0000 + off;
            6: return 32'h0001_0000 + off;
            default: return 32'h3000_0000 + off;
        endcase
    endfunction

    // Half the requests follow a shared region so both masters collide
    task automatic drive_master(input int m);
        int rgn;
        for (int i = 0; i < NUM_TXN; i++) begin
            @(negedge clk_i);
            rgn = ($urandom % 2 != 0) ? (i / 8) % 6 : int'($urandom % ((m == 0) ? 8 : 6));
            add[m]   = pick_addr(rgn);
            wen[m]   = $urandom % 2 != 0;
            wdata[m] = $urandom;
            be[m]    = 4'($urandom);
            req[m]   = 1'b1;
            @(posedge clk_i);
            while (!gnt[m]) @(posedge clk_i);
        end
        @(negedge clk_i);
        req[m] = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Slave models
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk_i) begin
        for (int b = 0; b < 4; b++) begin
            if (l2_req_o[b] && l2_gnt_i[b]) begin
                if (!l2_wen_o[b]) mem[l2_add_o[b]] = l2_wdata_o[b];
                l2_rd_q[b] = mem.exists(l2_add_o[b]) ? mem[l2_add_o[b]] : '0;
            end
        end
        for (int c = 0; c < 3; c++) begin
            if (contig_req_o[c] && contig_gnt_i[c]) begin
                if (!contig_wen_o[c]) mem[contig_add_o[c]] = contig_wdata_o[c];
                contig_rd_q[c] = mem.exists(contig_add_o[c]) ? mem[contig_add_o[c]] : '0;
            end
        end
        if (psel_o && penable_o && pready_i && pwrite_o && !pslverr_i) begin
            apb_regs[paddr_o] = pwdata_o;
        end
    end

    always @(negedge clk_i) begin
        for (int b = 0; b < 4; b++) begin
            l2_gnt_i[b]   = ($urandom % 4) != 0;
            l2_rdata_i[b] = l2_rd_q[b];
        end
        for (int c = 0; c < 3; c++) begin
            contig_gnt_i[c]   = ($urandom % 4) != 0;
            contig_rdata_i[c] = contig_rd_q[c];
        end
        // APB slave with 0 to 3 wait states
        pready_i = 1'b0;
        if (psel_o && !penable_o) begin
            wait_cnt = $urandom % 4;
        end else if (psel_o && penable_o) begin
            if (wait_cnt == 0) begin
                pready_i  = 1'b1;
                pslverr_i = paddr_o > 32'h1A3F_0000;
                prdata_i  = apb_regs.exists(paddr_o) ? apb_regs[paddr_o] : '0;
            end else begin
                wait_cnt--;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Scoreboard
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk_i) begin
        logic [31:0] a;
        int tg [2];
        int won [8];
        if (!rst_n_i) begin
            for (int m = 0; m < 2; m++) pend[m] = 1'b0;
            for (int t = 0; t < 8; t++) lose_v[t] = 1'b0;
        end else begin
            assert (uut.props.fail_cnt == 0) else fail_text("A protocol property fired");
            for (int t = 0; t < 8; t++) won[t] = -1;
            for (int m = 0; m < 2; m++) begin
                // Response due one cycle after the grant
                if (pend[m]) begin
                    assert (rvalid[m]) else fail_value("r_valid_o", 32'(rvalid[m]), 1);
                    assert (ropc[m] == pend_err[m])
                        else fail_value("r_opc_o", 32'(ropc[m]), 32'(pend_err[m]));
                    if ((pend_rd[m] && !pend_err[m]) || pend_unm[m])
                        assert (rdata[m] == pend_data[m])
                            else fail_value("r_rdata_o", rdata[m], pend_data[m]);
                end else begin
                    assert (!rvalid[m]) else fail_value("r_valid_o", 32'(rvalid[m]), 0);
                end
                a     = remap(m, add[m]);
                tg[m] = req[m] ? target_of(a) : -1;
                if (tg[m] == 8) assert (gnt[m]) else fail_text("Unmapped request not granted");
                pend[m] = req[m] && gnt[m];
                if (pend[m]) begin
                    pend_rd[m]   = wen[m];
                    pend_unm[m]  = tg[m] == 8;
                    pend_err[m]  = tg[m] == 8 || (tg[m] == 7 && pslverr_i);
                    pend_data[m] = (ref_mem.exists(a) && tg[m] != 8) ? ref_mem[a] : '0;
                    if (tg[m] == 7 && !wen[m])
                        assert (pwdata_o == wdata[m])
                            else fail_value("pwdata_o", pwdata_o, wdata[m]);
                    // Byte enables reach the memory port of the granted master
                    if (tg[m] < 4) begin
                        assert (l2_be_o[tg[m]] == be[m])
                            else fail_value("l2_be_o", 32'(l2_be_o[tg[m]]), 32'(be[m]));
                    end else if (tg[m] < 7) begin
                        assert (contig_be_o[tg[m] - 4] == be[m])
                            else fail_value("contig_be_o", 32'(contig_be_o[tg[m] - 4]),
                                            32'(be[m]));
                    end
                    if (!wen[m] && !pend_err[m]) ref_mem[a] = wdata[m];
                    if (tg[m] < 8) won[tg[m]] = m;
                end
            end
            // A waiting master wins the next grant at its target
            for (int t = 0; t < 8; t++) begin
                if (won[t] >= 0) begin
                    if (lose_v[t]) assert (won[t] == lose_m[t])
                        else fail_value("granted master", 32'(won[t]), 32'(lose_m[t]));
                    lose_v[t] = tg[0] == t && tg[1] == t;
                    lose_m[t] = 1 - won[t];
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS * 1ns);
        fail_text("Run timed out before all transactions finished");
    end

    initial begin
        void'($urandom(32'he223));
        rst_n_i = 1'b0;
        for (int m = 0; m < 2; m++) begin
            req[m] = 1'b0;
            wen[m] = 1'b1;
            add[m] = '0;
            wdata[m] = '0;
            be[m] = 4'hF;
        end
        l2_gnt_i = '0;
        l2_rdata_i = '0;
        contig_gnt_i = '0;
        contig_rdata_i = '0;
        pready_i = 1'b0;
        prdata_i = '0;
        pslverr_i = 1'b0;
        wait_cnt = 0;
        repeat (10) @(negedge clk_i);
        rst_n_i = 1'b1;
        fork
            drive_master(0);
            drive_master(1);
        join
        repeat (4) @(negedge clk_i);
        if (uut.props.fail_cnt != 0) begin
            $display("Verification failed");
            $fatal(1);
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tests/soc_xbar_props.sv
// Routing and APB protocol properties bound to the crossbar top level
`timescale 1ns/1ps
`default_nettype none

module soc_xbar_props
    import soc_xbar_pkg::*;
(
    input logic                                clk_i,
    input logic                                rst_n_i,
    input logic [NUM_L2_BANKS-1:0]             l2_req_o,
    input logic [NUM_L2_BANKS-1:0][ADDR_W-1:0] l2_add_o,
    input logic [NUM_CONTIG-1:0]               contig_req_o,
    input logic [NUM_CONTIG-1:0][ADDR_W-1:0]   contig_add_o,
    input logic [ADDR_W-1:0]                   paddr_o,
    input logic                                psel_o,
    input logic                                penable_o,
    input logic                                pwrite_o,
    input logic [DATA_W-1:0]                   pwdata_o,
    input logic                                pready_i
);

    localparam logic [ADDR_W-1:0] C_START [NUM_CONTIG] =
        '{PRIV_BANK0_START, PRIV_BANK1_START, BOOT_ROM_START};
    localparam logic [ADDR_W-1:0] C_END [NUM_CONTIG] =
        '{PRIV_BANK0_END, PRIV_BANK1_END, BOOT_ROM_END};

    // Count of fired properties that the testbench polls
    int unsigned fail_cnt = 0;

    //////////////////////////////////////////////////////////////////////
    // Routing and interleaving
    //////////////////////////////////////////////////////////////////////
    for (genvar b = 0; b < NUM_L2_BANKS; b++) begin : g_l2
        a_l2_route: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            l2_req_o[b] |-> (l2_add_o[b] >= L2_INTLV_START && l2_add_o[b] < L2_INTLV_END
                             && l2_add_o[b][3:2] == 2'(b)))
            else begin
                $error("L2 request off its bank");
                fail_cnt++;
            end
    end

    for (genvar c = 0; c < NUM_CONTIG; c++) begin : g_contig
        a_contig_route: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            contig_req_o[c] |-> (contig_add_o[c] >= C_START[c] && contig_add_o[c] < C_END[c]))
            else begin
                $error("Contiguous request outside its region");
                fail_cnt++;
            end
    end

    // APB setup is always followed by access
    a_apb_setup: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        psel_o && !penable_o |=> psel_o && penable_o)
        else begin
            $error("APB setup not followed by access");
            fail_cnt++;
        end

    // Transfer fields hold while the slave stalls
    a_apb_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        psel_o && penable_o && !pready_i |=> psel_o && penable_o && $stable(paddr_o)
            && $stable(pwrite_o) && $stable(pwdata_o))
        else begin
            $error("APB transfer changed before pready");
            fail_cnt++;
        end

endmodule

bind soc_xbar_top soc_xbar_props props (.*);

`default_nettype wire

// File: src/soc_xbar_top.sv
// SoC crossbar top joining the FC ports to L2 banks, contiguous memories and APB
`timescale 1ns/1ps
`default_nettype none

module soc_xbar_top
    import soc_xbar_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    // FC data port
    input  logic                                fc_data_req_i,
    input  logic [ADDR_W-1:0]                   fc_data_add_i,
    input  logic                                fc_data_wen_i,
    input  logic [DATA_W-1:0]                   fc_data_wdata_i,
    input  logic [BE_W-1:0]                     fc_data_be_i,
    output logic                                fc_data_gnt_o,
    output logic [DATA_W-1:0]                   fc_data_r_rdata_o,
    output logic                                fc_data_r_valid_o,
    output logic                                fc_data_r_opc_o,
    // FC instruction port
    input  logic                                fc_instr_req_i,
    input  logic [ADDR_W-1:0]                   fc_instr_add_i,
    input  logic                                fc_instr_wen_i,
    input  logic [DATA_W-1:0]                   fc_instr_wdata_i,
    input  logic [BE_W-1:0]                     fc_instr_be_i,
    output logic                                fc_instr_gnt_o,
    output logic [DATA_W-1:0]                   fc_instr_r_rdata_o,
    output logic                                fc_instr_r_valid_o,
    output logic                                fc_instr_r_opc_o,
    // Interleaved L2 banks
    output logic [NUM_L2_BANKS-1:0]             l2_req_o,
    output logic [NUM_L2_BANKS-1:0][ADDR_W-1:0] l2_add_o,
    output logic [NUM_L2_BANKS-1:0]             l2_wen_o,
    output logic [NUM_L2_BANKS-1:0][DATA_W-1:0] l2_wdata_o,
    output logic [NUM_L2_BANKS-1:0][BE_W-1:0]   l2_be_o,
    input  logic [NUM_L2_BANKS-1:0]             l2_gnt_i,
    input  logic [NUM_L2_BANKS-1:0][DATA_W-1:0] l2_rdata_i,
    // Private banks and boot ROM
    output logic [NUM_CONTIG-1:0]               contig_req_o,
    output logic [NUM_CONTIG-1:0][ADDR_W-1:0]   contig_add_o,
    output logic [NUM_CONTIG-1:0]               contig_wen_o,
    output logic [NUM_CONTIG-1:0][DATA_W-1:0]   contig_wdata_o,
    output logic [NUM_CONTIG-1:0][BE_W-1:0]     contig_be_o,
    input  logic [NUM_CONTIG-1:0]               contig_gnt_i,
    input  logic [NUM_CONTIG-1:0][DATA_W-1:0]   contig_rdata_i,
    // Peripheral APB
    output logic [ADDR_W-1:0]                   paddr_o,
    output logic                                psel_o,
    output logic                                penable_o,
    output logic                                pwrite_o,
    output logic [DATA_W-1:0]                   pwdata_o,
    input  logic                                pready_i,
    input  logic [DATA_W-1:0]                   prdata_i,
    input  logic                                pslverr_i
);

    // Per-master lanes, one per target, plus the arbiter output lanes
    tcdm_if fcd_lane [NUM_TARGETS] ();
    tcdm_if fci_lane [NUM_TARGETS] ();
    tcdm_if tgt_lane [NUM_TARGETS] ();

    tcdm_master_port #(.LEGACY_REMAP(1'b1)) i_fc_data_port (
        .clk_i, .rst_n_i,
        .req_i(fc_data_req_i), .add_i(fc_data_add_i), .wen_i(fc_data_wen_i),
        .wdata_i(fc_data_wdata_i), .be_i(fc_data_be_i), .gnt_o(fc_data_gnt_o),
        .r_rdata_o(fc_data_r_rdata_o), .r_valid_o(fc_data_r_valid_o),
        .r_opc_o(fc_data_r_opc_o), .lane_o(fcd_lane)
    );

    tcdm_master_port #(.LEGACY_REMAP(1'b0)) i_fc_instr_port (
        .clk_i, .rst_n_i,
        .req_i(fc_instr_req_i), .add_i(fc_instr_add_i), .wen_i(fc_instr_wen_i),
        .wdata_i(fc_instr_wdata_i), .be_i(fc_instr_be_i), .gnt_o(fc_instr_gnt_o),
        .r_rdata_o(fc_instr_r_rdata_o), .r_valid_o(fc_instr_r_valid_o),
        .r_opc_o(fc_instr_r_opc_o), .lane_o(fci_lane)
    );

    //////////////////////////////////////////////////////////////////////
    // Per-target arbitration and target mapping
    //////////////////////////////////////////////////////////////////////
    for (genvar t = 0; t < NUM_TARGETS; t++) begin : g_tgt
        tcdm_if arb_lane [NUM_MASTERS] ();

        // Gather lane t of both masters, fc_data first
        assign arb_lane[0].req     = fcd_lane[t].req;
        assign arb_lane[0].add     = fcd_lane[t].add;
        assign arb_lane[0].wen     = fcd_lane[t].wen;
        assign arb_lane[0].wdata   = fcd_lane[t].wdata;
        assign arb_lane[0].be      = fcd_lane[t].be;
        assign fcd_lane[t].gnt     = arb_lane[0].gnt;
        assign fcd_lane[t].r_rdata = arb_lane[0].r_rdata;
        assign fcd_lane[t].r_valid = arb_lane[0].r_valid;
        assign fcd_lane[t].r_opc   = arb_lane[0].r_opc;
        assign arb_lane[1].req     = fci_lane[t].req;
        assign arb_lane[1].add     = fci_lane[t].add;
        assign arb_lane[1].wen     = fci_lane[t].wen;
        assign arb_lane[1].wdata   = fci_lane[t].wdata;
        assign arb_lane[1].be      = fci_lane[t].be;
        assign fci_lane[t].gnt     = arb_lane[1].gnt;
        assign fci_lane[t].r_rdata = arb_lane[1].r_rdata;
        assign fci_lane[t].r_valid = arb_lane[1].r_valid;
        assign fci_lane[t].r_opc   = arb_lane[1].r_opc;

        tcdm_target_arbiter i_arb (
            .clk_i, .rst_n_i, .mst_i(arb_lane), .tgt_o(tgt_lane[t])
        );

        // Memories answer one cycle after grant and never flag errors
        if (t < TGT_CONTIG) begin : g_l2
            assign l2_req_o[t]         = tgt_lane[t].req;
            assign l2_add_o[t]         = tgt_lane[t].add;
            assign l2_wen_o[t]         = tgt_lane[t].wen;
            assign l2_wdata_o[t]       = tgt_lane[t].wdata;
            assign l2_be_o[t]          = tgt_lane[t].be;
            assign tgt_lane[t].gnt     = l2_gnt_i[t];
            assign tgt_lane[t].r_rdata = l2_rdata_i[t];
            assign tgt_lane[t].r_valid = 1'b0;
            assign tgt_lane[t].r_opc   = 1'b0;
        end else if (t < TGT_PERIPH) begin : g_contig
            assign contig_req_o[t-TGT_CONTIG]   = tgt_lane[t].req;
            assign contig_add_o[t-TGT_CONTIG]   = tgt_lane[t].add;
            assign contig_wen_o[t-TGT_CONTIG]   = tgt_lane[t].wen;
            assign contig_wdata_o[t-TGT_CONTIG] = tgt_lane[t].wdata;
            assign contig_be_o[t-TGT_CONTIG]    = tgt_lane[t].be;
            assign tgt_lane[t].gnt              = contig_gnt_i[t-TGT_CONTIG];
            assign tgt_lane[t].r_rdata          = contig_rdata_i[t-TGT_CONTIG];
            assign tgt_lane[t].r_valid          = 1'b0;
            assign tgt_lane[t].r_opc            = 1'b0;
        end else begin : g_apb
            tcdm_apb_bridge i_apb_bridge (
                .clk_i, .rst_n_i, .tgt_i(tgt_lane[t]),
                .paddr_o, .psel_o, .penable_o, .pwrite_o, .pwdata_o,
                .pready_i, .prdata_i, .pslverr_i
            );
        end
    end

endmodule

`default_nettype wire

// File: src/tcdm_apb_bridge.sv
// TCDM to APB bridge running one setup and access transfer per request
`timescale 1ns/1ps
`default_nettype none

module tcdm_apb_bridge
    import soc_xbar_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_n_i,
    tcdm_if.slave             tgt_i,
    output logic [ADDR_W-1:0] paddr_o,
    output logic              psel_o,
    output logic              penable_o,
    output logic              pwrite_o,
    output logic [DATA_W-1:0] pwdata_o,
    input  logic              pready_i,
    input  logic [DATA_W-1:0] prdata_i,
    input  logic              pslverr_i
);

    logic [1:0]        state_q;
    logic [1:0]        state_d;
    logic [ADDR_W-1:0] addr_q;
    logic              write_q;
    logic [DATA_W-1:0] wdata_q;
    logic [DATA_W-1:0] rdata_q;
    logic              err_q;
    logic              rsp_vld_q;
    logic              done;

    // Access phase ends when the slave is ready
    assign done = (state_q == APB_ACCESS) && pready_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            APB_IDLE:   if (tgt_i.req) state_d = APB_SETUP;
            APB_SETUP:  state_d = APB_ACCESS;
            APB_ACCESS: if (pready_i) state_d = APB_IDLE;
            default:    state_d = APB_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= APB_IDLE;
            rsp_vld_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            rsp_vld_q <= done;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Transfer and response payload
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (state_q == APB_IDLE && tgt_i.req) begin
            addr_q  <= tgt_i.add;
            // TCDM wen high is a read
            write_q <= !tgt_i.wen;
            wdata_q <= tgt_i.wdata;
        end
        if (done) begin
            rdata_q <= prdata_i;
            err_q   <= pslverr_i;
        end
    end

    assign paddr_o   = addr_q;
    assign pwrite_o  = write_q;
    assign pwdata_o  = wdata_q;
    assign psel_o    = (state_q != APB_IDLE);
    assign penable_o = (state_q == APB_ACCESS);

    // Grant lands on completion, response one cycle later
    assign tgt_i.gnt     = done;
    assign tgt_i.r_valid = rsp_vld_q;
    assign tgt_i.r_rdata = rdata_q;
    assign tgt_i.r_opc   = err_q;

endmodule

`default_nettype wire

// File: src/tcdm_target_arbiter.sv
// Round-robin TCDM arbiter for one target with response return routing
`timescale 1ns/1ps
`default_nettype none

module tcdm_target_arbiter
    import soc_xbar_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_n_i,
    tcdm_if.slave  mst_i [NUM_MASTERS],
    tcdm_if.master tgt_o
);

    logic [NUM_MASTERS-1:0] mst_req;
    logic [NUM_MASTERS-1:0] mst_wen;
    logic [ADDR_W-1:0]      mst_add   [NUM_MASTERS];
    logic [DATA_W-1:0]      mst_wdata [NUM_MASTERS];
    logic [BE_W-1:0]        mst_be    [NUM_MASTERS];
    logic [MST_W-1:0]       rr_q;
    logic [MST_W-1:0]       pick;
    logic [MST_W-1:0]       lock_idx_q;
    logic [MST_W-1:0]       rsp_idx_q;
    logic                   any_req;
    logic                   lock_q;
    logic                   rsp_vld_q;
    logic                   fire;

    for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_mst
        assign mst_req[m]   = mst_i[m].req;
        assign mst_wen[m]   = mst_i[m].wen;
        assign mst_add[m]   = mst_i[m].add;
        assign mst_wdata[m] = mst_i[m].wdata;
        assign mst_be[m]    = mst_i[m].be;
        // Grant and response only reach the chosen master
        assign mst_i[m].gnt     = fire && (pick == MST_W'(m));
        assign mst_i[m].r_valid = rsp_vld_q && (rsp_idx_q == MST_W'(m));
        assign mst_i[m].r_rdata = tgt_o.r_rdata;
        assign mst_i[m].r_opc   = tgt_o.r_opc;
    end

    //////////////////////////////////////////////////////////////////////
    // Master selection
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        int idx;
        pick    = rr_q;
        any_req = |mst_req;
        // Walk down so the master nearest the pointer wins
        for (int k = NUM_MASTERS - 1; k >= 0; k--) begin
            idx = (int'(rr_q) + k) % NUM_MASTERS;
            if (mst_req[idx]) begin
                pick = MST_W'(idx);
            end
        end
        // A stalled request keeps the target until it is accepted
        if (lock_q) begin
            pick = lock_idx_q;
        end
    end

    assign fire        = any_req && tgt_o.gnt;
    assign tgt_o.req   = any_req;
    assign tgt_o.add   = mst_add[pick];
    assign tgt_o.wen   = mst_wen[pick];
    assign tgt_o.wdata = mst_wdata[pick];
    assign tgt_o.be    = mst_be[pick];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rr_q       <= '0;
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
            rsp_vld_q  <= 1'b0;
            rsp_idx_q  <= '0;
        end else begin
            lock_q     <= any_req && !tgt_o.gnt;
            lock_idx_q <= pick;
            rsp_vld_q  <= fire;
            if (fire) begin
                rsp_idx_q <= pick;
                // Pointer moves past the winner
                rr_q <= (pick == MST_W'(NUM_MASTERS - 1)) ? '0 : pick + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/tcdm_master_port.sv
// TCDM master port that remaps, decodes, steers one request and selects its response
`timescale 1ns/1ps
`default_nettype none

module tcdm_master_port
    import soc_xbar_pkg::*;
#(
    parameter bit LEGACY_REMAP = 1'b0
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              req_i,
    input  logic [ADDR_W-1:0] add_i,
    input  logic              wen_i,
    input  logic [DATA_W-1:0] wdata_i,
    input  logic [BE_W-1:0]   be_i,
    output logic              gnt_o,
    output logic [DATA_W-1:0] r_rdata_o,
    output logic              r_valid_o,
    output logic              r_opc_o,
    tcdm_if.master            lane_o [NUM_TARGETS]
);

    l2_addr_u               addr;
    logic                   hit;
    logic [TGT_W-1:0]       tgt_sel;
    logic [NUM_TARGETS-1:0] lane_gnt;
    logic [NUM_TARGETS-1:0] lane_rvalid;
    logic [NUM_TARGETS-1:0] lane_ropc;
    logic [DATA_W-1:0]      lane_rdata [NUM_TARGETS];
    logic [TGT_W-1:0]       rsp_tgt_q;
    logic                   rsp_err_q;

    // Legacy alias: prefix 0x000 reads as 0x1C0 on the data port
    always_comb begin
        addr.raw = add_i;
        if (LEGACY_REMAP && add_i[31:20] == LEGACY_PREFIX) begin
            addr.raw[31:20] = SOC_PREFIX;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Region decode
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        hit     = 1'b1;
        tgt_sel = '0;
        if (addr.raw >= L2_INTLV_START && addr.raw < L2_INTLV_END) begin
            // Word interleaved, bank from address bits 3:2
            tgt_sel = TGT_W'(addr.intlv.bank);
        end else if (addr.raw >= PRIV_BANK0_START && addr.raw < PRIV_BANK0_END) begin
            tgt_sel = TGT_W'(TGT_CONTIG);
        end else if (addr.raw >= PRIV_BANK1_START && addr.raw < PRIV_BANK1_END) begin
            tgt_sel = TGT_W'(TGT_CONTIG + 1);
        end else if (addr.raw >= BOOT_ROM_START && addr.raw < BOOT_ROM_END) begin
            tgt_sel = TGT_W'(TGT_CONTIG + 2);
        end else if (addr.raw >= PERIPH_START && addr.raw < PERIPH_END) begin
            tgt_sel = TGT_W'(TGT_PERIPH);
        end else begin
            hit = 1'b0;
        end
    end

    // Only the decoded lane sees req, all lanes share the payload
    for (genvar t = 0; t < NUM_TARGETS; t++) begin : g_lane
        assign lane_o[t].req   = req_i && hit && (tgt_sel == TGT_W'(t));
        assign lane_o[t].add   = addr.raw;
        assign lane_o[t].wen   = wen_i;
        assign lane_o[t].wdata = wdata_i;
        assign lane_o[t].be    = be_i;
        assign lane_gnt[t]     = lane_o[t].gnt;
        assign lane_rvalid[t]  = lane_o[t].r_valid;
        assign lane_ropc[t]    = lane_o[t].r_opc;
        assign lane_rdata[t]   = lane_o[t].r_rdata;
    end

    // Unmapped requests are accepted on the spot
    assign gnt_o = req_i && (hit ? lane_gnt[tgt_sel] : 1'b1);

    // Remember where the granted request went
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_tgt_q <= '0;
            rsp_err_q <= 1'b0;
        end else begin
            rsp_err_q <= req_i && !hit;
            if (gnt_o) begin
                rsp_tgt_q <= tgt_sel;
            end
        end
    end

    // Error response carries zero data
    assign r_valid_o = rsp_err_q || lane_rvalid[rsp_tgt_q];
    assign r_opc_o   = rsp_err_q || (lane_rvalid[rsp_tgt_q] && lane_ropc[rsp_tgt_q]);
    assign r_rdata_o = rsp_err_q ? '0 : lane_rdata[rsp_tgt_q];

endmodule

`default_nettype wire

// File: src/tcdm_if.sv
// TCDM request and response bundle between master ports, arbiters and targets
`timescale 1ns/1ps
`default_nettype none

interface tcdm_if
    import soc_xbar_pkg::*;
();

    // Request half
    logic              req;
    logic [ADDR_W-1:0] add;
    logic              wen;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;

    // Grant and response half
    logic              gnt;
    logic [DATA_W-1:0] r_rdata;
    logic              r_valid;
    logic              r_opc;

    modport master (output req, add, wen, wdata, be, input gnt, r_rdata, r_valid, r_opc);
    modport slave (input req, add, wen, wdata, be, output gnt, r_rdata, r_valid, r_opc);

endinterface

`default_nettype wire

// File: src/soc_xbar_pkg.sv
// SoC interconnect package with memory map, port counts, bus widths and address views
`default_nettype none

package soc_xbar_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = 4;

    // Masters: 0 is fc_data, 1 is fc_instr
    localparam int NUM_MASTERS = 2;
    localparam int MST_W       = 1;

    // Targets: L2 banks first, then contiguous targets, peripherals last
    localparam int NUM_L2_BANKS = 4;
    localparam int NUM_CONTIG   = 3;
    localparam int NUM_TARGETS  = 8;
    localparam int TGT_W        = 3;
    localparam int TGT_CONTIG   = NUM_L2_BANKS;
    localparam int TGT_PERIPH   = NUM_L2_BANKS + NUM_CONTIG;

    //////////////////////////////////////////////////////////////////////
    // Memory map, start inclusive and end exclusive
    //////////////////////////////////////////////////////////////////////
    localparam logic [ADDR_W-1:0] L2_INTLV_START   = 32'h1C01_0000;
    localparam logic [ADDR_W-1:0] L2_INTLV_END     = 32'h1C09_0000;
    localparam logic [ADDR_W-1:0] PRIV_BANK0_START = 32'h1C00_0000;
    localparam logic [ADDR_W-1:0] PRIV_BANK0_END   = 32'h1C00_8000;
    localparam logic [ADDR_W-1:0] PRIV_BANK1_START = 32'h1C00_8000;
    localparam logic [ADDR_W-1:0] PRIV_BANK1_END   = 32'h1C01_0000;
    localparam logic [ADDR_W-1:0] BOOT_ROM_START   = 32'h1A00_0000;
    localparam logic [ADDR_W-1:0] BOOT_ROM_END     = 32'h1A04_0000;
    localparam logic [ADDR_W-1:0] PERIPH_START     = 32'h1A10_0000;
    localparam logic [ADDR_W-1:0] PERIPH_END       = 32'h1A40_0000;

    // Legacy data-port alias, top 12 address bits
    localparam logic [11:0] LEGACY_PREFIX = 12'h000;
    localparam logic [11:0] SOC_PREFIX    = 12'h1C0;

    // APB bridge FSM encoding
    localparam logic [1:0] APB_IDLE   = 2'd0;
    localparam logic [1:0] APB_SETUP  = 2'd1;
    localparam logic [1:0] APB_ACCESS = 2'd2;

    // One address word, seen raw for region compares or split for bank interleaving
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [27:0] row;
            logic [1:0]  bank;
            logic [1:0]  offset;
        } intlv;
    } l2_addr_u;

endpackage

`default_nettype wire
